// ==== hdl/soc_ctrl_pkg.sv ====
// SoC control package with register bus and APB types, address map and widths
`default_nettype none

package soc_ctrl_pkg;

  // --------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // --------------------------------------------------------------------
  // Register bus
  // --------------------------------------------------------------------
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 write;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] wstrb;
    logic                 valid;
  } reg_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 ready;
    logic                 error;
  } reg_rsp_t;

  // --------------------------------------------------------------------
  // APB
  // --------------------------------------------------------------------
  typedef struct packed {
    logic [AddrWidth-1:0] paddr;
    logic                 pwrite;
    logic [DataWidth-1:0] pwdata;
    logic [StrbWidth-1:0] pstrb;
    logic                 psel;
    logic                 penable;
  } apb_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] prdata;
    logic                 pready;
    logic                 pslverr;
  } apb_rsp_t;

  // Decoded register bus target
  typedef enum logic [1:0] {
    tgt_cfg  = 2'd0,
    tgt_rom  = 2'd1,
    tgt_apb  = 2'd2,
    tgt_none = 2'd3
  } tgt_sel_t;

  // Address map, base and window size in bytes
  localparam logic [AddrWidth-1:0] CfgRegsBase = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] CfgRegsSize = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] BootRomBase = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] BootRomSize = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] ApbBase     = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] ApbSize     = 32'h0001_0000;

  // Config register offsets inside the cfg window
  localparam logic [AddrWidth-1:0] CfgClkGateOffset = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] CfgBypassOffset  = 32'h0000_0004;

endpackage

`default_nettype wire

// ==== hdl/reg_addr_decode.sv ====
// Register bus address decoder steering requests to cfg, ROM or APB targets
`timescale 1ns/10ps
`default_nettype none

module reg_addr_decode (
  input  soc_ctrl_pkg::reg_req_t req_i,
  output soc_ctrl_pkg::reg_rsp_t rsp_o,
  output soc_ctrl_pkg::reg_req_t cfg_req_o,
  input  soc_ctrl_pkg::reg_rsp_t cfg_rsp_i,
  output soc_ctrl_pkg::reg_req_t rom_req_o,
  input  soc_ctrl_pkg::reg_rsp_t rom_rsp_i,
  output soc_ctrl_pkg::reg_req_t apb_req_o,
  input  soc_ctrl_pkg::reg_rsp_t apb_rsp_i
);

  soc_ctrl_pkg::tgt_sel_t sel;

  // Window hit test, offset from base compared unsigned against size
  always_comb begin
    if ((req_i.addr - soc_ctrl_pkg::CfgRegsBase) < soc_ctrl_pkg::CfgRegsSize) begin
      sel = soc_ctrl_pkg::tgt_cfg;
    end else if ((req_i.addr - soc_ctrl_pkg::BootRomBase) < soc_ctrl_pkg::BootRomSize) begin
      sel = soc_ctrl_pkg::tgt_rom;
    end else if ((req_i.addr - soc_ctrl_pkg::ApbBase) < soc_ctrl_pkg::ApbSize) begin
      sel = soc_ctrl_pkg::tgt_apb;
    end else begin
      sel = soc_ctrl_pkg::tgt_none;
    end
  end

  // Same payload to every target, valid only toward the selected one
  always_comb begin
    cfg_req_o       = req_i;
    rom_req_o       = req_i;
    apb_req_o       = req_i;
    cfg_req_o.valid = req_i.valid & (sel == soc_ctrl_pkg::tgt_cfg);
    rom_req_o.valid = req_i.valid & (sel == soc_ctrl_pkg::tgt_rom);
    apb_req_o.valid = req_i.valid & (sel == soc_ctrl_pkg::tgt_apb);
  end

  // Response return path
  always_comb begin
    case (sel)
      soc_ctrl_pkg::tgt_cfg: rsp_o = cfg_rsp_i;
      soc_ctrl_pkg::tgt_rom: rsp_o = rom_rsp_i;
      soc_ctrl_pkg::tgt_apb: rsp_o = apb_rsp_i;
      default: begin
        // Unmapped, complete at once with error
        rsp_o.rdata = '0;
        rsp_o.ready = req_i.valid;
        rsp_o.error = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/soc_cfg_regs.sv ====
// Top-level config registers holding per-cluster clock-gate and memory bypass bits
`timescale 1ns/10ps
`default_nettype none

module soc_cfg_regs #(
  parameter int unsigned NumClusters = 5
) (
  input  logic                   soc_clk_i,
  input  logic                   reset_i,
  input  soc_ctrl_pkg::reg_req_t req_i,
  output soc_ctrl_pkg::reg_rsp_t rsp_o,
  output logic [NumClusters-1:0] clu_clk_en_o,
  output logic [NumClusters-1:0] wide_mem_bypass_o
);

  logic [soc_ctrl_pkg::AddrWidth-1:0] offset;
  logic                               hit_gate;
  logic                               hit_bypass;
  logic                               wr_en;
  logic [NumClusters-1:0]             clk_gate_q;
  logic [NumClusters-1:0]             bypass_q;

  // ------------------------------------------------------------------
  // Offset decode
  // ------------------------------------------------------------------
  assign offset     = req_i.addr - soc_ctrl_pkg::CfgRegsBase;
  assign hit_gate   = (offset == soc_ctrl_pkg::CfgClkGateOffset);
  assign hit_bypass = (offset == soc_ctrl_pkg::CfgBypassOffset);

  // Only byte lane 0 carries the cluster bits
  assign wr_en = req_i.valid & req_i.write & req_i.wstrb[0];

  // ------------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------------
  always_ff @(posedge soc_clk_i) begin
    if (reset_i) begin
      clk_gate_q <= '0;
      bypass_q   <= '0;
    end else if (wr_en) begin
      if (hit_gate) begin
        clk_gate_q <= req_i.wdata[NumClusters-1:0];
      end
      if (hit_bypass) begin
        bypass_q <= req_i.wdata[NumClusters-1:0];
      end
    end
  end

  // ------------------------------------------------------------------
  // Read-back and response, answered in the request cycle
  // ------------------------------------------------------------------
  always_comb begin
    rsp_o.rdata = '0;
    rsp_o.ready = req_i.valid;
    rsp_o.error = req_i.valid & ~(hit_gate | hit_bypass);
    if (hit_gate) begin
      rsp_o.rdata[NumClusters-1:0] = clk_gate_q;
    end else if (hit_bypass) begin
      rsp_o.rdata[NumClusters-1:0] = bypass_q;
    end
  end

  // A set gate bit stops the cluster clock
  assign clu_clk_en_o      = ~clk_gate_q;
  assign wide_mem_bypass_o = bypass_q;

endmodule

`default_nettype wire

// ==== hdl/boot_rom_port.sv ====
// Boot ROM behind the register bus with a registered one-cycle response
`timescale 1ns/10ps
`default_nettype none

module boot_rom_port #(
  parameter int unsigned RomWords = 16
) (
  input  logic                   soc_clk_i,
  input  logic                   reset_i,
  input  soc_ctrl_pkg::reg_req_t req_i,
  output soc_ctrl_pkg::reg_rsp_t rsp_o
);

  localparam int unsigned IdxWidth = (RomWords > 1) ? $clog2(RomWords) : 1;

  logic [soc_ctrl_pkg::DataWidth-1:0] rom_mem [RomWords];
  logic [IdxWidth-1:0]                word_idx;
  logic                               accept;
  logic [soc_ctrl_pkg::DataWidth-1:0] rdata_q;
  logic                               rsp_valid_q;
  logic                               werr_q;

  initial begin
    $readmemh("hdl/boot_rom.hex", rom_mem);
  end

  // Word index from addr[5:2], wrapped into the table
  assign word_idx = IdxWidth'(req_i.addr[5:2] % RomWords);

  // No new accept while the previous answer is on the bus
  assign accept = req_i.valid & ~rsp_valid_q;

  // ------------------------------------------------------------------
  // Response flags
  // ------------------------------------------------------------------
  always_ff @(posedge soc_clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
      werr_q      <= 1'b0;
    end else begin
      rsp_valid_q <= accept;
      werr_q      <= accept & req_i.write;
    end
  end

  // Read word, writes return zero data
  always_ff @(posedge soc_clk_i) begin
    if (accept) begin
      rdata_q <= req_i.write ? '0 : rom_mem[word_idx];
    end
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.ready = rsp_valid_q;
  assign rsp_o.error = werr_q;

endmodule

`default_nettype wire

// ==== hdl/reg_to_apb_bridge.sv ====
// Register bus to APB bridge with setup and access phases
`timescale 1ns/10ps
`default_nettype none

module reg_to_apb_bridge (
  input  logic                   soc_clk_i,
  input  logic                   reset_i,
  input  soc_ctrl_pkg::reg_req_t req_i,
  output soc_ctrl_pkg::reg_rsp_t rsp_o,
  output soc_ctrl_pkg::apb_req_t apb_req_o,
  input  soc_ctrl_pkg::apb_rsp_t apb_rsp_i
);

  typedef enum logic [1:0] {
    st_idle   = 2'd0,
    st_setup  = 2'd1,
    st_access = 2'd2
  } state_t;

  state_t                             state_q;
  state_t                             state_d;
  logic                               done;
  logic [soc_ctrl_pkg::AddrWidth-1:0] paddr_q;
  logic                               pwrite_q;
  logic [soc_ctrl_pkg::DataWidth-1:0] pwdata_q;
  logic [soc_ctrl_pkg::StrbWidth-1:0] pstrb_q;

  // Access phase ends on pready
  assign done = (state_q == st_access) & apb_rsp_i.pready;

  // ------------------------------------------------------------------
  // Phase FSM
  // ------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle:   if (req_i.valid) state_d = st_setup;
      st_setup:  state_d = st_access;
      st_access: if (apb_rsp_i.pready) state_d = st_idle;
      default:   state_d = st_idle;
    endcase
  end

  always_ff @(posedge soc_clk_i) begin
    if (reset_i) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Request held for the whole transfer, address rebased to the APB window
  always_ff @(posedge soc_clk_i) begin
    if ((state_q == st_idle) && req_i.valid) begin
      paddr_q  <= req_i.addr - soc_ctrl_pkg::ApbBase;
      pwrite_q <= req_i.write;
      pwdata_q <= req_i.wdata;
      pstrb_q  <= req_i.wstrb;
    end
  end

  // ------------------------------------------------------------------
  // APB and register bus outputs
  // ------------------------------------------------------------------
  assign apb_req_o.paddr   = paddr_q;
  assign apb_req_o.pwrite  = pwrite_q;
  assign apb_req_o.pwdata  = pwdata_q;
  assign apb_req_o.pstrb   = pstrb_q;
  assign apb_req_o.psel    = (state_q != st_idle);
  assign apb_req_o.penable = (state_q == st_access);

  assign rsp_o.rdata = apb_rsp_i.prdata;
  assign rsp_o.ready = done;
  assign rsp_o.error = done & apb_rsp_i.pslverr;

endmodule

`default_nettype wire

// ==== hdl/soc_ctrl_top.sv ====
// SoC control top joining the address decoder, config registers, boot ROM and APB bridge
`timescale 1ns/10ps
`default_nettype none

module soc_ctrl_top #(
  parameter int unsigned NumClusters = 5,
  parameter int unsigned RomWords    = 16
) (
  input  logic                   soc_clk_i,
  input  logic                   reset_i,
  input  soc_ctrl_pkg::reg_req_t reg_req_i,
  output soc_ctrl_pkg::reg_rsp_t reg_rsp_o,
  output soc_ctrl_pkg::apb_req_t apb_req_o,
  input  soc_ctrl_pkg::apb_rsp_t apb_rsp_i,
  output logic [NumClusters-1:0] clu_clk_en_o,
  output logic [NumClusters-1:0] wide_mem_bypass_o
);

  // Per-target register bus links
  soc_ctrl_pkg::reg_req_t cfg_req;
  soc_ctrl_pkg::reg_rsp_t cfg_rsp;
  soc_ctrl_pkg::reg_req_t rom_req;
  soc_ctrl_pkg::reg_rsp_t rom_rsp;
  soc_ctrl_pkg::reg_req_t apb_reg_req;
  soc_ctrl_pkg::reg_rsp_t apb_reg_rsp;

  reg_addr_decode u_reg_addr_decode (
    .req_i    (reg_req_i),
    .rsp_o    (reg_rsp_o),
    .cfg_req_o(cfg_req),
    .cfg_rsp_i(cfg_rsp),
    .rom_req_o(rom_req),
    .rom_rsp_i(rom_rsp),
    .apb_req_o(apb_reg_req),
    .apb_rsp_i(apb_reg_rsp)
  );

  soc_cfg_regs #(
    .NumClusters(NumClusters)
  ) u_soc_cfg_regs (
    .soc_clk_i        (soc_clk_i),
    .reset_i          (reset_i),
    .req_i            (cfg_req),
    .rsp_o            (cfg_rsp),
    .clu_clk_en_o     (clu_clk_en_o),
    .wide_mem_bypass_o(wide_mem_bypass_o)
  );

  boot_rom_port #(
    .RomWords(RomWords)
  ) u_boot_rom_port (
    .soc_clk_i(soc_clk_i),
    .reset_i  (reset_i),
    .req_i    (rom_req),
    .rsp_o    (rom_rsp)
  );

  reg_to_apb_bridge u_reg_to_apb_bridge (
    .soc_clk_i(soc_clk_i),
    .reset_i  (reset_i),
    .req_i    (apb_reg_req),
    .rsp_o    (apb_reg_rsp),
    .apb_req_o(apb_req_o),
    .apb_rsp_i(apb_rsp_i)
  );

endmodule

`default_nettype wire

// ==== verif/soc_ctrl_properties.sv ====
// Bound protocol assertions for the register bus and APB ports of the SoC control top
`timescale 1ns/10ps
`default_nettype none

module soc_ctrl_properties (
  input logic                   soc_clk_i,
  input logic                   reset_i,
  input soc_ctrl_pkg::reg_req_t reg_req_i,
  input soc_ctrl_pkg::reg_rsp_t reg_rsp_o,
  input soc_ctrl_pkg::apb_req_t apb_req_o,
  input soc_ctrl_pkg::apb_rsp_t apb_rsp_i
);

  // Failed assertion count, read by the testbench at the end of the run
  int fail_cnt = 0;

  // A response only completes a pending request
  ready_needs_valid: assert property (@(posedge soc_clk_i) disable iff (reset_i)
    reg_rsp_o.ready |-> reg_req_i.valid)
    else begin
      fail_cnt++;
      $error("register bus ready raised without valid");
    end

  // Access phase follows exactly one setup cycle
  penable_after_setup: assert property (@(posedge soc_clk_i) disable iff (reset_i)
    $rose(apb_req_o.penable) |-> ($past(apb_req_o.psel) && !$past(apb_req_o.psel, 2)))
    else begin
      fail_cnt++;
      $error("APB penable rose without exactly one preceding setup cycle");
    end

  // Request held while the slave inserts wait states
  apb_stable_in_access: assert property (@(posedge soc_clk_i) disable iff (reset_i)
    (apb_req_o.penable && !apb_rsp_i.pready) |=>
      (apb_req_o.penable && $stable(apb_req_o.paddr) && $stable(apb_req_o.pwrite) &&
       $stable(apb_req_o.pwdata) && $stable(apb_req_o.pstrb)))
    else begin
      fail_cnt++;
      $error("APB request changed during the access phase");
    end

endmodule

bind soc_ctrl_top soc_ctrl_properties u_soc_ctrl_properties (
  .soc_clk_i(soc_clk_i),
  .reset_i  (reset_i),
  .reg_req_i(reg_req_i),
  .reg_rsp_o(reg_rsp_o),
  .apb_req_o(apb_req_o),
  .apb_rsp_i(apb_rsp_i)
);

`default_nettype wire

// ==== verif/soc_ctrl_checker.sv ====
// Checker that models the SoC control block and compares every completed transfer
`timescale 1ns/10ps
`default_nettype none

module soc_ctrl_checker #(
  parameter int unsigned NumClusters = 5,
  parameter int unsigned RomWords    = 16
) (
  input logic                   soc_clk_i,
  input logic                   reset_i,
  input soc_ctrl_pkg::reg_req_t reg_req_i,
  input soc_ctrl_pkg::reg_rsp_t reg_rsp_i,
  input soc_ctrl_pkg::apb_req_t apb_req_i,
  input soc_ctrl_pkg::apb_rsp_t apb_rsp_i,
  input logic [NumClusters-1:0] clu_clk_en_i,
  input logic [NumClusters-1:0] wide_mem_bypass_i
);

  int                     err_total;
  int                     tests_run;
  int                     tests_failed;
  int                     test_start_errs;
  int                     wait_cycles;
  int                     apb_done;
  logic [NumClusters-1:0] gate_sh;
  logic [NumClusters-1:0] byp_sh;
  logic [31:0]            rom_model [RomWords];
  logic [31:0]            apb_model [256];

  initial begin
    $readmemh("hdl/boot_rom.hex", rom_model);
    for (int i = 0; i < 256; i++) begin
      apb_model[i] = 32'h0;
    end
    err_total       = 0;
    tests_run       = 0;
    tests_failed    = 0;
    test_start_errs = 0;
    wait_cycles     = 0;
    apb_done        = 0;
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("** Error: %s expected 0x%08h got 0x%08h", name, exp, got);
      err_total++;
    end
  endtask

  task automatic flag_failure(input string what);
    $display("Failure: %s", what);
    err_total++;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (err_total == test_start_errs) begin
      $display("Test %s: pass", name);
    end else begin
      $display("Test %s: FAIL with %0d errors", name, err_total - test_start_errs);
      tests_failed++;
    end
    test_start_errs = err_total;
  endtask

  function automatic bit is_apb(input logic [31:0] addr);
    return (addr >= 32'h0001_0000) && (addr < 32'h0002_0000);
  endfunction

  // ------------------------------------------------------------------
  // Reference model of one completed transfer
  // ------------------------------------------------------------------
  task automatic check_transfer(input int lat);
    logic [31:0] addr;
    logic [31:0] off;
    logic [31:0] exp_rd;
    logic        exp_err;
    addr = reg_req_i.addr;
    if (addr < 32'h0000_1000) begin
      exp_err = !(addr == 32'h0 || addr == 32'h4);
      exp_rd  = (addr == 32'h0) ? 32'(gate_sh) : (addr == 32'h4) ? 32'(byp_sh) : 32'h0;
      check_value("cfg rdata", exp_rd, reg_rsp_i.rdata);
      check_value("cfg error", 32'(exp_err), 32'(reg_rsp_i.error));
      check_value("cfg ready latency", 32'd0, 32'(lat));
      if (reg_req_i.write && reg_req_i.wstrb[0]) begin
        if (addr == 32'h0) gate_sh = reg_req_i.wdata[NumClusters-1:0];
        if (addr == 32'h4) byp_sh = reg_req_i.wdata[NumClusters-1:0];
      end
    end else if (addr < 32'h0000_2000) begin
      check_value("rom error", 32'(reg_req_i.write), 32'(reg_rsp_i.error));
      check_value("rom ready latency", 32'd1, 32'(lat));
      if (!reg_req_i.write) begin
        check_value("rom rdata", rom_model[32'(addr[5:2]) % RomWords], reg_rsp_i.rdata);
      end
    end else if (is_apb(addr)) begin
      off     = addr - 32'h0001_0000;
      exp_err = (off >= 32'h0000_8000);
      check_value("apb error", 32'(exp_err), 32'(reg_rsp_i.error));
      check_value("apb handshakes", 32'd1, 32'(apb_done));
      if (lat < 2) flag_failure("APB transfer completed in fewer than two cycles");
      if (!exp_err && reg_req_i.write) apb_model[off[9:2]] = reg_req_i.wdata;
      if (!exp_err && !reg_req_i.write) begin
        check_value("apb rdata", apb_model[off[9:2]], reg_rsp_i.rdata);
      end
    end else begin
      check_value("unmapped rdata", 32'h0, reg_rsp_i.rdata);
      check_value("unmapped error", 32'h1, 32'(reg_rsp_i.error));
      check_value("unmapped ready latency", 32'd0, 32'(lat));
    end
  endtask

  always @(posedge soc_clk_i) begin
    if (reset_i) begin
      gate_sh     = '0;
      byp_sh      = '0;
      wait_cycles = 0;
      apb_done    = 0;
    end else if (reg_req_i.valid) begin
      if (apb_req_i.psel) begin
        check_value("paddr", reg_req_i.addr - 32'h0001_0000, apb_req_i.paddr);
        check_value("pwrite", 32'(reg_req_i.write), 32'(apb_req_i.pwrite));
        check_value("pstrb", 32'(reg_req_i.wstrb), 32'(apb_req_i.pstrb));
        if (reg_req_i.write) begin
          check_value("pwdata", reg_req_i.wdata, apb_req_i.pwdata);
        end
        // Completed access phase
        if (apb_req_i.penable && apb_rsp_i.pready) begin
          apb_done++;
        end
      end
      if (reg_rsp_i.ready) begin
        check_transfer(wait_cycles);
        wait_cycles = 0;
        apb_done    = 0;
      end else begin
        wait_cycles++;
      end
    end
  end

  // Cluster outputs and APB idle checked mid-cycle
  always @(negedge soc_clk_i) begin
    logic [NumClusters-1:0] exp_en;
    exp_en = ~gate_sh;
    if (!reset_i) begin
      check_value("clu_clk_en_o", 32'(exp_en), 32'(clu_clk_en_i));
      check_value("wide_mem_bypass_o", 32'(byp_sh), 32'(wide_mem_bypass_i));
      if (apb_req_i.psel && !(reg_req_i.valid && is_apb(reg_req_i.addr))) begin
        flag_failure("APB select raised outside an APB transfer");
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_soc_ctrl.sv ====
// Testbench for the SoC control block with random stimulus and an APB slave model
`timescale 1ns/10ps
`default_nettype none

module tb_soc_ctrl;

  localparam int unsigned NumClusters = 5;
  localparam int unsigned RomWords    = 16;
  localparam int          Timeout     = 50;

  logic                   soc_clk_i;
  logic                   reset_i;
  soc_ctrl_pkg::reg_req_t reg_req;
  soc_ctrl_pkg::reg_rsp_t reg_rsp;
  soc_ctrl_pkg::apb_req_t apb_req;
  soc_ctrl_pkg::apb_rsp_t apb_rsp;
  logic [NumClusters-1:0] clu_clk_en;
  logic [NumClusters-1:0] wide_mem_bypass;
  integer                 seed;
  logic [31:0]            rnd;
  logic [31:0]            addr;
  logic [1:0]             wait_cnt;
  logic [31:0]            slave_mem [256];

  soc_ctrl_top #(
    .NumClusters(NumClusters),
    .RomWords   (RomWords)
  ) u_soc_ctrl_top (
    .soc_clk_i        (soc_clk_i),
    .reset_i          (reset_i),
    .reg_req_i        (reg_req),
    .reg_rsp_o        (reg_rsp),
    .apb_req_o        (apb_req),
    .apb_rsp_i        (apb_rsp),
    .clu_clk_en_o     (clu_clk_en),
    .wide_mem_bypass_o(wide_mem_bypass)
  );

  soc_ctrl_checker #(
    .NumClusters(NumClusters),
    .RomWords   (RomWords)
  ) u_soc_ctrl_checker (
    .soc_clk_i        (soc_clk_i),
    .reset_i          (reset_i),
    .reg_req_i        (reg_req),
    .reg_rsp_i        (reg_rsp),
    .apb_req_i        (apb_req),
    .apb_rsp_i        (apb_rsp),
    .clu_clk_en_i     (clu_clk_en),
    .wide_mem_bypass_i(wide_mem_bypass)
  );

  always #5 soc_clk_i = ~soc_clk_i;

  // ------------------------------------------------------------------
  // APB slave, 0 to 3 wait states, error from offset 0x8000 up
  // ------------------------------------------------------------------
  always @(negedge soc_clk_i) begin
    if (apb_req.psel && !apb_req.penable) begin
      rnd            = $random(seed);
      wait_cnt       = rnd[1:0];
      apb_rsp.pready = 1'b0;
    end else if (apb_req.psel && apb_req.penable && !apb_rsp.pready) begin
      if (wait_cnt == 2'd0) begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = (apb_req.paddr >= 32'h0000_8000);
        apb_rsp.prdata  = slave_mem[apb_req.paddr[9:2]];
        if (apb_req.pwrite && !apb_rsp.pslverr) slave_mem[apb_req.paddr[9:2]] = apb_req.pwdata;
      end else begin
        wait_cnt = wait_cnt - 2'd1;
      end
    end else begin
      apb_rsp = '0;
    end
  end

  // One register bus transfer, request held until ready
  task automatic bus_xfer(input logic [31:0] a, input logic wr, input logic [31:0] wd,
                          input logic [3:0] strb);
    int cnt;
    cnt = 0;
    @(negedge soc_clk_i);
    reg_req.addr  = a;
    reg_req.write = wr;
    reg_req.wdata = wd;
    reg_req.wstrb = strb;
    reg_req.valid = 1'b1;
    #1;
    while (!reg_rsp.ready && cnt < Timeout) begin
      @(negedge soc_clk_i);
      #1;
      cnt++;
    end
    if (!reg_rsp.ready) begin
      u_soc_ctrl_checker.flag_failure(
        $sformatf("no ready within %0d cycles at address 0x%08h", Timeout, a));
    end
    @(negedge soc_clk_i);
    reg_req.valid = 1'b0;
  endtask

  initial begin
    seed      = 32'hb38c_d520;
    soc_clk_i = 1'b0;
    reset_i   = 1'b1;
    reg_req   = '0;
    apb_rsp   = '0;
    wait_cnt  = 2'd0;
    for (int i = 0; i < 256; i++) begin
      slave_mem[i] = 32'h0;
    end
    repeat (4) @(posedge soc_clk_i);
    @(negedge soc_clk_i);
    reset_i = 1'b0;

    bus_xfer(32'h0, 1'b0, 32'h0, 4'h0);
    bus_xfer(32'h4, 1'b0, 32'h0, 4'h0);
    u_soc_ctrl_checker.report_test("reset_state");

    repeat (24) begin
      rnd = $random(seed);
      case (rnd[1:0])
        2'd0: bus_xfer(32'h0, 1'b1, $random(seed), rnd[7:4]);
        2'd1: bus_xfer(32'h4, 1'b1, $random(seed), rnd[7:4]);
        2'd2: bus_xfer({29'h0, rnd[2], 2'b00}, 1'b0, 32'h0, 4'h0);
        default: bus_xfer({20'h0, rnd[11:4], 4'h8}, rnd[12], $random(seed), 4'hf);
      endcase
    end
    u_soc_ctrl_checker.report_test("cfg_random");

    repeat (16) begin
      rnd = $random(seed);
      bus_xfer({20'h00001, rnd[11:2], 2'b00}, 1'b0, 32'h0, 4'h0);
    end
    bus_xfer(32'h0000_1004, 1'b1, 32'hdead_beef, 4'hf);
    bus_xfer(32'h0000_1008, 1'b0, 32'h0, 4'h0);
    u_soc_ctrl_checker.report_test("boot_rom");

    repeat (12) begin
      rnd  = $random(seed);
      addr = {16'h0001, rnd[15:2], 2'b00};
      bus_xfer(addr, 1'b1, $random(seed), 4'hf);
      bus_xfer(addr, 1'b0, 32'h0, 4'h0);
    end
    u_soc_ctrl_checker.report_test("apb_bridge");

    repeat (10) begin
      rnd = $random(seed);
      if (rnd[0]) begin
        addr = rnd | 32'h0002_0000;
      end else begin
        addr = 32'h0000_2000 + 32'(rnd[31:16] % 16'he000);
      end
      bus_xfer(addr, rnd[1], $random(seed), 4'hf);
    end
    u_soc_ctrl_checker.report_test("unmapped");

    $display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
             u_soc_ctrl_checker.tests_run, u_soc_ctrl_checker.tests_failed,
             u_soc_ctrl_checker.err_total, u_soc_ctrl_top.u_soc_ctrl_properties.fail_cnt);
    if (u_soc_ctrl_checker.err_total == 0 &&
        u_soc_ctrl_top.u_soc_ctrl_properties.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/boot_rom.hex ====
// One 32-bit boot ROM word per line, word index 0 to 15
b007_0000
b007_1111
b007_2222
b007_3333
1cea_4004
1cea_5115
1cea_6226
1cea_7337
d00d_8008
d00d_9119
d00d_a22a
d00d_b33b
5eed_c00c
5eed_d11d
5eed_e22e
5eed_f33f

// ==== sim.f ====
hdl/soc_ctrl_pkg.sv
hdl/reg_addr_decode.sv
hdl/soc_cfg_regs.sv
hdl/boot_rom_port.sv
hdl/reg_to_apb_bridge.sv
hdl/soc_ctrl_top.sv
verif/soc_ctrl_properties.sv
verif/soc_ctrl_checker.sv
verif/tb_soc_ctrl.sv

// ==== Makefile ====
# Verilator simulation of the SoC control block

VERILATOR ?= verilator
TOP       ?= tb_soc_ctrl
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
